/* verilog/fetchFront_defines.svh */
// Fetch front end parameters
`ifndef FETCH_FRONT_DEFINES_SVH
`define FETCH_FRONT_DEFINES_SVH

// Instruction and register data width
`define FF_DATA_W 32

// Fetch address width
`define FF_ADDR_W 32

// First fetch address after reset
`define FF_RESET_PC 32'h0000_0000

// Interrupt synchroniser depth
`define FF_SYNC_STAGES 2

// Vector base plus this gives the interrupt target
`define FF_INT_OFFSET 16

// Control register bus address width
`define FF_REG_ADDR_W 2

`endif

/* verilog/isaPkg.sv */
// Instruction set types
`default_nettype none

package isaPkg;

   // Major opcode, bits 31:26 of the instruction word
   typedef enum logic [5:0] {
      ADD  = 6'o00,
      ADDI = 6'o10,
      // Two-cycle arithmetic
      MUL  = 6'o20,
      BSF  = 6'o21,
      MULI = 6'o30,
      BSFI = 6'o31,
      ORI  = 6'o50,
      // Branch group
      BR   = 6'o46,
      BCC  = 6'o47,
      IMM  = 6'o54,
      RTD  = 6'o55,
      BRI  = 6'o56,
      BCCI = 6'o57,
      // Loads, register and immediate forms
      LBU  = 6'o60,
      LHU  = 6'o61,
      LW   = 6'o62,
      LBUI = 6'o70,
      LHUI = 6'o71,
      LWI  = 6'o72,
      // Stores
      SB   = 6'o64,
      SH   = 6'o65,
      SW   = 6'o66,
      SBI  = 6'o74,
      SHI  = 6'o75,
      SWI  = 6'o76
   } opcodeE;

   // Decode field widths
   typedef logic [4:0]  regIdxT;
   typedef logic [10:0] altT;
   typedef logic [15:0] immT;

   // BRI ra field with absolute and link bits set, brali form
   localparam regIdxT BRALI_FLAGS = 5'b01100;

   // Interrupt return address goes to r14
   localparam regIdxT INT_LINK_REG = 5'd14;

endpackage

`default_nettype wire

/* verilog/busPkg.sv */
// Bus side types
`default_nettype none

`include "fetchFront_defines.svh"

package busPkg;

   // Instruction fetch master states
   typedef enum logic [1:0] {
      IDLE,
      BUSREQ,
      HOLD
   } fetchStateE;

   // Control register map
   typedef enum logic [`FF_REG_ADDR_W-1:0] {
      CTRL     = 0,
      VECBASE  = 1,
      RESTART  = 2,
      INTCOUNT = 3
   } ctrlRegE;

   // Interrupt enable position in CTRL
   localparam int CTRL_IE_BIT = 0;

endpackage

`default_nettype wire

/* verilog/instFetch.sv */
// Instruction fetch master
`timescale 1ns/100ps
`default_nettype none

`include "fetchFront_defines.svh"

module instFetch (
   input  wire                   gclk,
   input  wire                   grst,
   // Instruction bus, classic master
   output logic [`FF_ADDR_W-1:0] imemAdr,
   output logic                  imemCyc,
   output logic                  imemStb,
   input  wire  [`FF_DATA_W-1:0] imemDat,
   input  wire                   imemAck,
   // Holding slot towards the buffer
   output logic [`FF_DATA_W-1:0] fetchWord,
   output logic                  fetchValid,
   input  wire                   take,
   // Restart from control registers
   input  wire  [`FF_ADDR_W-1:0] restartPc,
   input  wire                   restartReq
);

   busPkg::fetchStateE state;
   logic [`FF_ADDR_W-1:0] pc;
   // Set when the outstanding ack belongs to a cancelled stream
   logic discard;

   // One bus cycle or one held word at a time
   assign imemCyc    = (state == busPkg::BUSREQ);
   assign imemStb    = (state == busPkg::BUSREQ);
   assign fetchValid = (state == busPkg::HOLD);

   always_ff @(posedge gclk) begin
      if (grst) begin
         state   <= busPkg::IDLE;
         pc      <= `FF_RESET_PC;
         imemAdr <= `FF_RESET_PC;
         discard <= 1'b0;
      end else begin
         case (state)
            busPkg::IDLE: begin
               // Slot empty, start a cycle right away
               state <= busPkg::BUSREQ;
               if (restartReq) begin
                  pc      <= restartPc;
                  imemAdr <= restartPc;
               end else begin
                  imemAdr <= pc;
               end
            end
            busPkg::BUSREQ: begin
               // Address must not move mid-cycle, only the PC
               if (restartReq) begin
                  pc <= restartPc;
               end
               if (imemAck) begin
                  discard <= 1'b0;
                  if (discard || restartReq) begin
                     // Stale word, drop it and refetch
                     state <= busPkg::IDLE;
                  end else begin
                     state <= busPkg::HOLD;
                     pc    <= pc + `FF_ADDR_W'(4);
                  end
               end else if (restartReq) begin
                  discard <= 1'b1;
               end
            end
            busPkg::HOLD: begin
               if (restartReq) begin
                  // Held word belongs to the old stream
                  pc    <= restartPc;
                  state <= busPkg::IDLE;
               end else if (take) begin
                  // Consumed, next request goes out now
                  state   <= busPkg::BUSREQ;
                  imemAdr <= pc;
               end
            end
            default: begin
               state <= busPkg::IDLE;
            end
         endcase
      end
   end

   // Word captured on the ack edge
   always_ff @(posedge gclk) begin
      if ((state == busPkg::BUSREQ) && imemAck) begin
         fetchWord <= imemDat;
      end
   end

   // No old-stream word survives a restart
   aRestartDrop: assert property (
      @(posedge gclk) disable iff (grst)
         restartReq |=> !fetchValid
   ) else $error("held word kept across a restart");

   // Classic handshake, request held steady until ack
   aAdrStable: assert property (
      @(posedge gclk) disable iff (grst)
         imemCyc && !imemAck |=> imemCyc && $stable(imemAdr)
   ) else $error("imem address moved before ack");

endmodule

`default_nettype wire

/* verilog/instBuffer.sv */
// Instruction decode buffer
`timescale 1ns/100ps
`default_nettype none

`include "fetchFront_defines.svh"

module instBuffer (
   input  wire                   gclk,
   input  wire                   grst,
   // Fetch slot
   input  wire  [`FF_DATA_W-1:0] fetchWord,
   input  wire                   fetchValid,
   output logic                  take,
   // Execute handshake
   input  wire                   decEn,
   input  wire                   opDone,
   // Interrupt
   input  wire                   intReq,
   input  wire                   intEnable,
   input  wire isaPkg::immT      vecBase,
   output logic                  intTaken,
   // Decode fields
   output isaPkg::opcodeE        opc,
   output isaPkg::regIdxT        rd,
   output isaPkg::regIdxT        ra,
   output isaPkg::regIdxT        rb,
   output isaPkg::altT           alt,
   output logic [`FF_DATA_W-1:0] simm,
   output logic                  decValid,
   output logic                  stall
);

   logic [`FF_SYNC_STAGES-1:0] syncQ;
   logic                       intPending;
   logic                       decUnsafe;
   logic                       slotReady;
   logic                       accept;
   logic                       inject;
   logic                       load;
   logic [`FF_DATA_W-1:0]      intTarget;
   logic [`FF_DATA_W-1:0]      injWord;
   logic [`FF_DATA_W-1:0]      nextWord;
   logic [`FF_DATA_W-1:0]      nextSimm;
   logic [5:0]                 nextOpBits;
   logic                       nextMulti;
   isaPkg::immT                immPrefix;

   // Level interrupt into the clock domain
   always_ff @(posedge gclk) begin
      if (grst) begin
         syncQ <= '0;
      end else begin
         syncQ <= {syncQ[`FF_SYNC_STAGES-2:0], intReq};
      end
   end

   // Pending latch, dropped when masked or serviced
   always_ff @(posedge gclk) begin
      if (grst) begin
         intPending <= 1'b0;
      end else begin
         intPending <= (intPending | syncQ[`FF_SYNC_STAGES-1]) & intEnable & ~inject;
      end
   end

   // Never break an IMM pair or a delay slot
   assign decUnsafe = (opc == isaPkg::IMM) || (opc == isaPkg::RTD) ||
                      (opc == isaPkg::BR)  || (opc == isaPkg::BRI) ||
                      (opc == isaPkg::BCC) || (opc == isaPkg::BCCI);

   // A word could move into decode this cycle
   assign slotReady = fetchValid & decEn & ~stall;
   assign inject    = slotReady & intPending & ~decUnsafe;
   // Injection leaves the fetched word in the slot
   assign take      = decEn & ~stall & ~inject;
   assign accept    = fetchValid & take;
   assign load      = accept | inject;
   assign intTaken  = inject;

   // brali r14, vecBase + offset
   assign intTarget = {{(`FF_DATA_W-16){1'b0}}, vecBase} + `FF_DATA_W'(`FF_INT_OFFSET);
   assign injWord   = {isaPkg::BRI, isaPkg::INT_LINK_REG, isaPkg::BRALI_FLAGS,
                       intTarget[15:0]};
   assign nextWord  = inject ? injWord : fetchWord;

   // Low half of the IMM still sitting in decode
   assign immPrefix = {rb, alt};

   always_comb begin
      if (inject) begin
         nextSimm = intTarget;
      end else if (opc == isaPkg::IMM) begin
         nextSimm = {immPrefix, nextWord[15:0]};
      end else begin
         nextSimm = {{(`FF_DATA_W-16){nextWord[15]}}, nextWord[15:0]};
      end
   end

   // Multiply, barrel shift, load and store take extra cycles
   assign nextOpBits = nextWord[31:26];
   assign nextMulti  = (nextOpBits == isaPkg::MUL) || (nextOpBits == isaPkg::MULI) ||
                       (nextOpBits == isaPkg::BSF) || (nextOpBits == isaPkg::BSFI) ||
                       ({nextOpBits[5:4], nextOpBits[2]} == 3'b110) ||
                       ({nextOpBits[5:4], nextOpBits[2]} == 3'b111);

   // Opcode reset keeps the injection check sane
   always_ff @(posedge gclk) begin
      if (grst) begin
         opc      <= isaPkg::ADD;
         decValid <= 1'b0;
      end else begin
         decValid <= load;
         if (load) begin
            opc <= isaPkg::opcodeE'(nextWord[31:26]);
         end
      end
   end

   always_ff @(posedge gclk) begin
      if (load) begin
         rd   <= nextWord[25:21];
         ra   <= nextWord[20:16];
         rb   <= nextWord[15:11];
         alt  <= nextWord[10:0];
         simm <= nextSimm;
      end
   end

   // Held from the cycle after acceptance until opDone
   always_ff @(posedge gclk) begin
      if (grst) begin
         stall <= 1'b0;
      end else if (accept && nextMulti) begin
         stall <= 1'b1;
      end else if (opDone) begin
         stall <= 1'b0;
      end
   end

   // One injection per pending request
   aIntPulse: assert property (
      @(posedge gclk) disable iff (grst)
         intTaken |=> !intTaken
   ) else $error("interrupt injected two cycles running");

   // Stall only ever follows a decoded multi-cycle op
   aStallOp: assert property (
      @(posedge gclk) disable iff (grst)
         $rose(stall) |-> decValid && (opc inside {isaPkg::MUL, isaPkg::MULI, isaPkg::BSF,
            isaPkg::BSFI, isaPkg::LBU, isaPkg::LHU, isaPkg::LW, isaPkg::LBUI, isaPkg::LHUI,
            isaPkg::LWI, isaPkg::SB, isaPkg::SH, isaPkg::SW, isaPkg::SBI, isaPkg::SHI,
            isaPkg::SWI})
   ) else $error("stall raised without a multi-cycle op in decode");

endmodule

`default_nettype wire

/* verilog/frontCtrlRegs.sv */
// Front end control registers
`timescale 1ns/100ps
`default_nettype none

`include "fetchFront_defines.svh"

module frontCtrlRegs (
   input  wire                       gclk,
   input  wire                       grst,
   // Register bus, classic slave
   input  wire  [`FF_REG_ADDR_W-1:0] cfgAdr,
   input  wire  [`FF_DATA_W-1:0]     cfgDatW,
   input  wire                       cfgWe,
   input  wire                       cfgCyc,
   input  wire                       cfgStb,
   output logic [`FF_DATA_W-1:0]     cfgDatR,
   output logic                      cfgAck,
   // Steering outputs
   output logic                      intEnable,
   output isaPkg::immT               vecBase,
   output logic [`FF_ADDR_W-1:0]     restartPc,
   output logic                      restartReq,
   input  wire                       intTaken
);

   logic            reqNew;
   logic            wrEn;
   logic [15:0]     intCount;
   logic [`FF_DATA_W-1:0] regVal;
   busPkg::ctrlRegE regSel;

   // Ack gap makes every held strobe a fresh request
   assign reqNew = cfgCyc & cfgStb & ~cfgAck;
   assign wrEn   = reqNew & cfgWe;
   assign regSel = busPkg::ctrlRegE'(cfgAdr);

   always_ff @(posedge gclk) begin
      if (grst) begin
         cfgAck     <= 1'b0;
         restartReq <= 1'b0;
         intEnable  <= 1'b0;
         vecBase    <= '0;
         restartPc  <= `FF_RESET_PC;
         intCount   <= '0;
      end else begin
         cfgAck     <= reqNew;
         restartReq <= wrEn && (regSel == busPkg::RESTART);
         // Taking an interrupt beats a same-cycle write
         if (intTaken) begin
            intEnable <= 1'b0;
         end else if (wrEn && (regSel == busPkg::CTRL)) begin
            intEnable <= cfgDatW[busPkg::CTRL_IE_BIT];
         end
         if (wrEn && (regSel == busPkg::VECBASE)) begin
            vecBase <= cfgDatW[15:0];
         end
         if (wrEn && (regSel == busPkg::RESTART)) begin
            restartPc <= cfgDatW[`FF_ADDR_W-1:0];
         end
         // Saturates at all ones
         if (intTaken && (intCount != 16'hFFFF)) begin
            intCount <= intCount + 16'd1;
         end
      end
   end

   always_comb begin
      regVal = '0;
      case (regSel)
         busPkg::CTRL:     regVal[busPkg::CTRL_IE_BIT] = intEnable;
         busPkg::VECBASE:  regVal[15:0] = vecBase;
         busPkg::RESTART:  regVal = `FF_DATA_W'(restartPc);
         busPkg::INTCOUNT: regVal[15:0] = intCount;
         default:          regVal = '0;
      endcase
   end

   // Read data lines up with ack
   always_ff @(posedge gclk) begin
      if (reqNew) begin
         cfgDatR <= regVal;
      end
   end

   aAckPulse: assert property (
      @(posedge gclk) disable iff (grst)
         cfgAck |=> !cfgAck
   ) else $error("cfg ack high two cycles running");

endmodule

`default_nettype wire

/* verilog/fetchFront.sv */
// Instruction front end top
`timescale 1ns/100ps
`default_nettype none

`include "fetchFront_defines.svh"

module fetchFront (
   input  wire                       gclk,
   input  wire                       grst,
   // Instruction memory
   output logic [`FF_ADDR_W-1:0]     imemAdr,
   output logic                      imemCyc,
   output logic                      imemStb,
   input  wire  [`FF_DATA_W-1:0]     imemDat,
   input  wire                       imemAck,
   // Control register bus
   input  wire  [`FF_REG_ADDR_W-1:0] cfgAdr,
   input  wire  [`FF_DATA_W-1:0]     cfgDatW,
   input  wire                       cfgWe,
   input  wire                       cfgCyc,
   input  wire                       cfgStb,
   output logic [`FF_DATA_W-1:0]     cfgDatR,
   output logic                      cfgAck,
   // Execute side
   input  wire                       decEn,
   input  wire                       opDone,
   input  wire                       intReq,
   output isaPkg::opcodeE            opc,
   output isaPkg::regIdxT            rd,
   output isaPkg::regIdxT            ra,
   output isaPkg::regIdxT            rb,
   output isaPkg::altT               alt,
   output logic [`FF_DATA_W-1:0]     simm,
   output logic                      decValid,
   output logic                      stall
);

   // Fetch slot handshake
   logic [`FF_DATA_W-1:0] fetchWord;
   logic                  fetchValid;
   logic                  take;
   // Control register steering
   logic [`FF_ADDR_W-1:0] restartPc;
   logic                  restartReq;
   logic                  intEnable;
   isaPkg::immT           vecBase;
   logic                  intTaken;

   instFetch uFetch (
      .gclk       (gclk),
      .grst       (grst),
      .imemAdr    (imemAdr),
      .imemCyc    (imemCyc),
      .imemStb    (imemStb),
      .imemDat    (imemDat),
      .imemAck    (imemAck),
      .fetchWord  (fetchWord),
      .fetchValid (fetchValid),
      .take       (take),
      .restartPc  (restartPc),
      .restartReq (restartReq)
   );

   instBuffer uBuffer (
      .gclk       (gclk),
      .grst       (grst),
      .fetchWord  (fetchWord),
      .fetchValid (fetchValid),
      .take       (take),
      .decEn      (decEn),
      .opDone     (opDone),
      .intReq     (intReq),
      .intEnable  (intEnable),
      .vecBase    (vecBase),
      .intTaken   (intTaken),
      .opc        (opc),
      .rd         (rd),
      .ra         (ra),
      .rb         (rb),
      .alt        (alt),
      .simm       (simm),
      .decValid   (decValid),
      .stall      (stall)
   );

   frontCtrlRegs uRegs (
      .gclk       (gclk),
      .grst       (grst),
      .cfgAdr     (cfgAdr),
      .cfgDatW    (cfgDatW),
      .cfgWe      (cfgWe),
      .cfgCyc     (cfgCyc),
      .cfgStb     (cfgStb),
      .cfgDatR    (cfgDatR),
      .cfgAck     (cfgAck),
      .intEnable  (intEnable),
      .vecBase    (vecBase),
      .restartPc  (restartPc),
      .restartReq (restartReq),
      .intTaken   (intTaken)
   );

endmodule

`default_nettype wire

/* verification/clockGen.sv */
// Testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module clockGen (
   output logic gclk,
   output logic grst
);

   // 100 ns period
   initial begin
      gclk = 1'b0;
      forever #50 gclk = ~gclk;
   end

   // Reset held for three rising edges, released on a falling edge
   initial begin
      grst = 1'b1;
      repeat (3) @(posedge gclk);
      @(negedge gclk);
      grst = 1'b0;
   end

endmodule

`default_nettype wire

/* verification/fetchFrontTb.sv */
// Fetch front end testbench
`timescale 1ns/100ps
`default_nettype none

`include "fetchFront_defines.svh"

module fetchFrontTb;

   logic gclk, grst;
   logic [`FF_ADDR_W-1:0] imemAdr;
   logic imemCyc, imemStb, imemAck;
   logic [`FF_DATA_W-1:0] imemDat;
   logic [`FF_REG_ADDR_W-1:0] cfgAdr;
   logic [`FF_DATA_W-1:0] cfgDatW, cfgDatR;
   logic cfgWe, cfgCyc, cfgStb, cfgAck;
   logic decEn, opDone, intReq;
   isaPkg::opcodeE opc;
   isaPkg::regIdxT rd, ra, rb;
   isaPkg::altT alt;
   logic [`FF_DATA_W-1:0] simm;
   logic decValid, stall;

   // Instruction memory table, 256 words
   logic [31:0] imem [0:255];
   integer seed = 32'h789e_500a;
   int delayLeft = -1;
   int errors = 0;
   int timeouts = 0;
   int decCount = 0;
   int injCount = 0;
   int stallRises = 0;
   int stallCnt = 0;
   int decMode = 0;
   logic intArmed = 1'b0;
   logic [31:0] expPc = `FF_RESET_PC;
   logic [15:0] vecBaseVal = 16'h0200;
   logic prevImm = 1'b0;
   logic prevUnsafe = 1'b0;
   logic [15:0] prevLow = '0;
   logic stallPrev = 1'b0;
   logic [31:0] rdata;
   logic [31:0] countBefore;

   clockGen uClk (.gclk(gclk), .grst(grst));

   fetchFront u_dut (
      .gclk(gclk), .grst(grst),
      .imemAdr(imemAdr), .imemCyc(imemCyc), .imemStb(imemStb),
      .imemDat(imemDat), .imemAck(imemAck),
      .cfgAdr(cfgAdr), .cfgDatW(cfgDatW), .cfgWe(cfgWe), .cfgCyc(cfgCyc),
      .cfgStb(cfgStb), .cfgDatR(cfgDatR), .cfgAck(cfgAck),
      .decEn(decEn), .opDone(opDone), .intReq(intReq),
      .opc(opc), .rd(rd), .ra(ra), .rb(rb), .alt(alt), .simm(simm),
      .decValid(decValid), .stall(stall)
   );

   task automatic endRun;
      $display("closing: errors=%0d timeouts=%0d decoded=%0d", errors, timeouts, decCount);
      if (errors == 0 && timeouts == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   endtask

   // Later waits fall through once one has expired
   task automatic timedOut(input string what);
      timeouts++;
      $display("Timed out at %0t waiting for %s", $time, what);
   endtask

   task automatic checkVal(input string name, input logic [31:0] expV, input logic [31:0] actV);
      if (timeouts == 0) begin
         aValue: assert (expV === actV) else begin
            errors++;
            $display("CHECK FAILED t=%0t %s expected %h actual %h", $time, name, expV, actV);
         end
      end
   endtask

   function automatic logic isUnsafeOp(input isaPkg::opcodeE op);
      return (op == isaPkg::IMM) || (op == isaPkg::RTD) || (op == isaPkg::BR) ||
             (op == isaPkg::BRI) || (op == isaPkg::BCC) || (op == isaPkg::BCCI);
   endfunction

   // Memory model, random ack delay of 0 to 3 cycles
   always @(negedge gclk) begin
      if (imemAck) begin
         imemAck = 1'b0;
         delayLeft = -1;
      end else if (imemCyc && imemStb) begin
         if (delayLeft < 0) begin
            delayLeft = $unsigned($random(seed)) % 4;
         end
         if (delayLeft == 0) begin
            imemAck = 1'b1;
            imemDat = imem[imemAdr[9:2]];
         end else begin
            delayLeft--;
         end
      end
   end

   // Decode enable off, on, or random gaps
   always @(negedge gclk) begin
      if (decMode == 2) begin
         decEn = (($random(seed) & 3) != 0);
      end else begin
         decEn = (decMode == 1);
      end
   end

   // Execute stand-in finishes a multi-cycle op after a few cycles
   always @(negedge gclk) begin
      opDone = 1'b0;
      if (stall) begin
         stallCnt++;
         if (stallCnt == 3) begin
            opDone = 1'b1;
         end
      end else begin
         stallCnt = 0;
      end
   end

   // Decode reference model
   always @(negedge gclk) begin
      logic [31:0] w;
      logic [31:0] eSimm;
      if (stall && !stallPrev) begin
         stallRises++;
      end
      stallPrev = stall;
      if (!grst && decValid) begin
         if (opc == isaPkg::BRI) begin
            injCount++;
            aInjArmed: assert (intArmed) else begin
               errors++;
               $display("Interrupt injected while masked at %0t", $time);
            end
            aInjSafe: assert (!prevUnsafe) else begin
               errors++;
               $display("Interrupt injected right after IMM or branch at %0t", $time);
            end
            checkVal("simm", 32'(vecBaseVal) + `FF_INT_OFFSET, simm);
            checkVal("rd", 32'd14, 32'(rd));
            checkVal("ra", 32'b01100, 32'(ra));
            prevImm = 1'b0;
         end else begin
            w = imem[expPc[9:2]];
            checkVal("opc", 32'(w[31:26]), 32'(opc));
            checkVal("rd", 32'(w[25:21]), 32'(rd));
            checkVal("ra", 32'(w[20:16]), 32'(ra));
            checkVal("rb", 32'(w[15:11]), 32'(rb));
            checkVal("alt", 32'(w[10:0]), 32'(alt));
            // IMM prefix supplies the high half
            eSimm = prevImm ? {prevLow, w[15:0]} : {{16{w[15]}}, w[15:0]};
            checkVal("simm", eSimm, simm);
            prevImm = (w[31:26] == isaPkg::IMM);
            prevLow = w[15:0];
            expPc = expPc + 32'd4;
         end
         prevUnsafe = isUnsafeOp(opc);
         decCount++;
      end
   end

   aStallQuiet: assert property (@(posedge gclk) disable iff (grst)
      stall && !$rose(stall) |-> !decValid)
   else begin
      errors++;
      $display("Word decoded during stall at %0t", $time);
   end
   aStallRise: assert property (@(posedge gclk) disable iff (grst)
      $rose(stall) |-> decValid)
   else begin
      errors++;
      $display("Stall rose without a decoded op at %0t", $time);
   end
   aStallFall: assert property (@(posedge gclk) disable iff (grst)
      stall && opDone |=> !stall)
   else begin
      errors++;
      $display("Stall did not fall after opDone at %0t", $time);
   end
   aStallKeep: assert property (@(posedge gclk) disable iff (grst)
      stall && !opDone |=> stall)
   else begin
      errors++;
      $display("Stall dropped without opDone at %0t", $time);
   end

   task automatic regAccess(input logic we, input logic [1:0] adr, input logic [31:0] wdata,
                            output logic [31:0] rd);
      int t;
      logic got;
      got = 1'b0;
      rd = '0;
      if (timeouts == 0) begin
         @(negedge gclk);
         cfgAdr = adr;
         cfgDatW = wdata;
         cfgWe = we;
         cfgCyc = 1'b1;
         cfgStb = 1'b1;
         for (t = 0; t < 20 && !got; t++) begin
            @(negedge gclk);
            if (cfgAck) begin
               got = 1'b1;
               rd = cfgDatR;
            end
         end
         cfgCyc = 1'b0;
         cfgStb = 1'b0;
         cfgWe = 1'b0;
         if (!got) begin
            timedOut("register bus ack");
         end
      end
   endtask

   task automatic waitDecodes(input int n);
      int target;
      int t;
      if (timeouts == 0) begin
         target = decCount + n;
         for (t = 0; t < 3000 && decCount < target; t++) begin
            @(negedge gclk);
         end
         if (decCount < target) begin
            timedOut("decoded words");
         end
      end
   endtask

   task automatic waitInjection(input int n);
      int t;
      if (timeouts == 0) begin
         for (t = 0; t < 500 && injCount < n; t++) begin
            @(negedge gclk);
         end
         if (injCount < n) begin
            timedOut("interrupt injection");
         end
      end
   endtask

   initial begin
      int i;
      cfgAdr = '0;
      cfgDatW = '0;
      cfgWe = 1'b0;
      cfgCyc = 1'b0;
      cfgStb = 1'b0;
      decEn = 1'b0;
      opDone = 1'b0;
      intReq = 1'b0;
      imemAck = 1'b0;
      imemDat = '0;
      // Fill pattern from the whole word index
      // Only one word in three is safe to inject after
      for (i = 0; i < 256; i++) begin
         imem[i] = {((i % 3 == 0) ? 6'(isaPkg::ORI) :
                     (i % 3 == 1) ? 6'(isaPkg::IMM) : 6'(isaPkg::BR)),
                    5'(i), 5'(i >> 3), 16'(i * 16'h2B1D ^ 16'h9C41)};
      end
      imem[16] = {6'(isaPkg::IMM), 10'd0, 16'hBEEF};
      imem[17] = {6'(isaPkg::ADDI), 5'd3, 5'd4, 16'h1234};
      imem[18] = {6'(isaPkg::ADDI), 5'd5, 5'd6, 16'hF00D};
      imem[24] = {6'(isaPkg::BR), 5'd0, 5'd0, 5'd7, 11'd0};
      imem[28] = {6'(isaPkg::MUL), 5'd1, 5'd2, 5'd3, 11'd0};
      imem[29] = {6'(isaPkg::BSFI), 5'd1, 5'd2, 16'h0405};
      imem[30] = {6'(isaPkg::LWI), 5'd4, 5'd5, 16'h0010};
      imem[31] = {6'(isaPkg::SW), 5'd6, 5'd7, 5'd8, 11'd0};

      // Reset state, sampled inside the reset window
      repeat (2) @(negedge gclk);
      checkVal("imemCyc", 32'd0, 32'(imemCyc));
      checkVal("imemStb", 32'd0, 32'(imemStb));
      checkVal("cfgAck", 32'd0, 32'(cfgAck));
      checkVal("decValid", 32'd0, 32'(decValid));
      checkVal("stall", 32'd0, 32'(stall));
      checkVal("imemAdr", `FF_RESET_PC, imemAdr);
      @(negedge gclk);

      // Sequential decode through immediates, branch and stalls
      decMode = 2;
      waitDecodes(40);
      checkVal("stallRises", 32'd4, 32'(stallRises));

      // Register readback and interrupt injection
      regAccess(1'b1, busPkg::VECBASE, 32'(vecBaseVal), rdata);
      regAccess(1'b0, busPkg::VECBASE, '0, rdata);
      checkVal("VECBASE", 32'(vecBaseVal), rdata);
      regAccess(1'b1, busPkg::CTRL, 32'd1, rdata);
      regAccess(1'b0, busPkg::CTRL, '0, rdata);
      checkVal("CTRL", 32'd1, rdata);
      regAccess(1'b0, busPkg::INTCOUNT, '0, countBefore);
      intArmed = 1'b1;
      intReq = 1'b1;
      waitInjection(1);
      intReq = 1'b0;
      waitDecodes(3);
      intArmed = 1'b0;
      regAccess(1'b0, busPkg::CTRL, '0, rdata);
      checkVal("CTRL", 32'd0, rdata);
      regAccess(1'b0, busPkg::INTCOUNT, '0, rdata);
      checkVal("INTCOUNT", countBefore + 32'd1, rdata);

      // Masked request
      intReq = 1'b1;
      waitDecodes(50);
      intReq = 1'b0;
      regAccess(1'b0, busPkg::INTCOUNT, '0, rdata);
      checkVal("INTCOUNT", countBefore + 32'd1, rdata);

      // Restart with decode held off so no old word slips through
      decMode = 0;
      repeat (4) @(negedge gclk);
      regAccess(1'b1, busPkg::RESTART, 32'h0000_0040, rdata);
      regAccess(1'b0, busPkg::RESTART, '0, rdata);
      checkVal("RESTART", 32'h0000_0040, rdata);
      expPc = 32'h0000_0040;
      decMode = 2;
      waitDecodes(12);

      endRun();
   end

endmodule

`default_nettype wire

/* fetchFront.f */
+incdir+verilog
verilog/isaPkg.sv
verilog/busPkg.sv
verilog/instFetch.sv
verilog/instBuffer.sv
verilog/frontCtrlRegs.sv
verilog/fetchFront.sv
verification/clockGen.sv
verification/fetchFrontTb.sv
